//--- dmem_defines.svh
`ifndef DMEM_DEFINES_SVH
`define DMEM_DEFINES_SVH

// Datapath and physical address widths
`define DMEM_XLEN 32
`define DMEM_PLEN 32

// Request buffer entries
`define DMEM_BUF_DEPTH 4

// PMA region table size
`define DMEM_PMA_CNT 4

// Access size codes
`define DMEM_SIZE_W    2
`define DMEM_SIZE_BYTE 2'd0
`define DMEM_SIZE_HALF 2'd1
`define DMEM_SIZE_WORD 2'd2

// PMA attribute field and its bit positions
`define DMEM_PMA_CFG_W 3
`define DMEM_PMA_EN    0
`define DMEM_PMA_RD    1
`define DMEM_PMA_WR    2

`endif

//--- dmem_pkg.sv
`default_nettype none

`include "dmem_defines.svh"

package dmem_pkg;

  ////////////////////////////////////////
  // Shared vector types
  ////////////////////////////////////////

  // One data word
  typedef logic [`DMEM_XLEN-1:0] data_t;

  // Physical address, no translation
  typedef logic [`DMEM_PLEN-1:0] addr_t;

  // Byte, half or word
  typedef logic [`DMEM_SIZE_W-1:0] size_t;

  // EN, RD and WR bits of one region
  typedef logic [`DMEM_PMA_CFG_W-1:0] pma_cfg_t;

endpackage

`default_nettype wire

//--- dmem_membuf.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_membuf #(
  parameter int DEPTH = 4
) (
  input  wire                  clk_i,
  input  wire                  rst_n_i,
  // Write side from the CPU
  input  wire                  push_i,
  input  wire dmem_pkg::addr_t push_adr_i,
  input  wire dmem_pkg::size_t push_size_i,
  input  wire                  push_we_i,
  input  wire dmem_pkg::data_t push_d_i,
  output logic                 ready_o,
  // Read side at the head of the queue
  input  wire                  pop_i,
  input  wire                  flush_i,
  output logic                 head_valid_o,
  output dmem_pkg::addr_t      head_adr_o,
  output dmem_pkg::size_t      head_size_o,
  output logic                 head_we_o,
  output dmem_pkg::data_t      head_d_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Entry storage
  dmem_pkg::addr_t adr_mem  [DEPTH];
  dmem_pkg::size_t size_mem [DEPTH];
  logic            we_mem   [DEPTH];
  dmem_pkg::data_t d_mem    [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push_en;
  logic             pop_en;

  assign ready_o      = (count != CNT_W'(DEPTH));
  assign head_valid_o = (count != '0);

  // A flush drops whatever arrives with it
  assign push_en = push_i & ready_o & ~flush_i;
  assign pop_en  = pop_i & head_valid_o & ~flush_i;

  ////////////////////////////////////////
  // Pointers and fill level
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_en, pop_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Payload write
  always_ff @(posedge clk_i) begin
    if (push_en) begin
      adr_mem[wr_ptr]  <= push_adr_i;
      size_mem[wr_ptr] <= push_size_i;
      we_mem[wr_ptr]   <= push_we_i;
      d_mem[wr_ptr]    <= push_d_i;
    end
  end

  // Head entry
  assign head_adr_o  = adr_mem[rd_ptr];
  assign head_size_o = size_mem[rd_ptr];
  assign head_we_o   = we_mem[rd_ptr];
  assign head_d_o    = d_mem[rd_ptr];

  // Bus side only pops a real entry
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> head_valid_o);

  // Full buffer has its write pointer back on the head
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !ready_o |-> (wr_ptr == rd_ptr));

endmodule

`default_nettype wire

//--- dmem_pmachk.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmem_defines.svh"

module dmem_pmachk (
  // Buffer head
  input  wire                       req_i,
  input  wire dmem_pkg::addr_t      adr_i,
  input  wire dmem_pkg::size_t      size_i,
  input  wire                       we_i,
  // Region table
  input  wire dmem_pkg::pma_cfg_t [`DMEM_PMA_CNT-1:0] pma_cfg_i,
  input  wire dmem_pkg::addr_t    [`DMEM_PMA_CNT-1:0] pma_base_i,
  input  wire dmem_pkg::addr_t    [`DMEM_PMA_CNT-1:0] pma_mask_i,
  // Check result
  output logic                      misaligned_o,
  output logic                      fault_o
);

  logic [`DMEM_PMA_CNT-1:0] region_hit;
  logic                     match;
  dmem_pkg::pma_cfg_t       match_cfg;
  logic                     perm_ok;
  logic                     misaligned;

  ////////////////////////////////////////
  // Alignment
  ////////////////////////////////////////

  always_comb begin
    case (size_i)
      `DMEM_SIZE_BYTE: begin
        misaligned = 1'b0;
      end
      `DMEM_SIZE_HALF: begin
        // Odd byte address
        misaligned = adr_i[0];
      end
      `DMEM_SIZE_WORD: begin
        // Must sit on a 4 byte boundary
        misaligned = |adr_i[1:0];
      end
      default: begin
        // No doubleword on RV32
        misaligned = 1'b1;
      end
    endcase
  end

  ////////////////////////////////////////
  // Region lookup
  ////////////////////////////////////////

  // Masked compare per enabled region
  always_comb begin
    for (int i = 0; i < `DMEM_PMA_CNT; i++) begin
      region_hit[i] = pma_cfg_i[i][`DMEM_PMA_EN] &&
                      ((adr_i & pma_mask_i[i]) == pma_base_i[i]);
    end
  end

  // Lowest index wins
  always_comb begin
    match     = 1'b0;
    match_cfg = '0;
    for (int i = 0; i < `DMEM_PMA_CNT; i++) begin
      if (!match && region_hit[i]) begin
        match     = 1'b1;
        match_cfg = pma_cfg_i[i];
      end
    end
  end

  // Read or write permission of the winner
  assign perm_ok = we_i ? match_cfg[`DMEM_PMA_WR] : match_cfg[`DMEM_PMA_RD];

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  assign misaligned_o = req_i & misaligned;

  // Misalignment hides any PMA fault
  assign fault_o = req_i & ~misaligned & (~match | ~perm_ok);

endmodule

`default_nettype wire

//--- dmem_bus_access.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_bus_access (
  input  wire                  clk_i,
  input  wire                  rst_n_i,
  // Buffer head and its check result
  input  wire                  head_valid_i,
  input  wire dmem_pkg::addr_t head_adr_i,
  input  wire dmem_pkg::size_t head_size_i,
  input  wire                  head_we_i,
  input  wire dmem_pkg::data_t head_d_i,
  input  wire                  misaligned_i,
  input  wire                  fault_i,
  // Buffer control
  output logic                 pop_o,
  output logic                 flush_o,
  // BIU
  output logic                 biu_stb_o,
  input  wire                  biu_stb_ack_i,
  output dmem_pkg::addr_t      biu_adr_o,
  output dmem_pkg::size_t      biu_size_o,
  output logic                 biu_we_o,
  output dmem_pkg::data_t      biu_d_o,
  input  wire dmem_pkg::data_t biu_q_i,
  input  wire                  biu_ack_i,
  input  wire                  biu_err_i,
  // CPU response
  output dmem_pkg::data_t      mem_q_o,
  output logic                 mem_ack_o,
  output logic                 mem_err_o,
  output logic                 mem_misaligned_o
);

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    DATA
  } bus_state_e;

  bus_state_e state_q;
  bus_state_e state_d;

  logic idle_bad;
  logic data_done;

  // Faulting head answered without a bus cycle
  assign idle_bad  = (state_q == IDLE) & head_valid_i & (misaligned_i | fault_i);
  // End of data phase
  assign data_done = (state_q == DATA) & (biu_ack_i | biu_err_i);

  ////////////////////////////////////////
  // Transfer FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (head_valid_i && !misaligned_i && !fault_i) begin
          state_d = ADDR;
        end
      end
      ADDR: begin
        // Wait for BIU to take the address
        if (biu_stb_ack_i) begin
          state_d = DATA;
        end
      end
      DATA: begin
        if (biu_ack_i || biu_err_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign biu_stb_o = (state_q == ADDR);

  // Capture head fields on the way into ADDR
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && state_d == ADDR) begin
      biu_adr_o  <= head_adr_i;
      biu_size_o <= head_size_i;
      biu_we_o   <= head_we_i;
      biu_d_o    <= head_d_i;
    end
  end

  ////////////////////////////////////////
  // Responses, pop and flush
  ////////////////////////////////////////

  // Retire head on fault or on bus completion
  assign pop_o   = idle_bad | data_done;
  // Any error drops the rest of the queue
  assign flush_o = idle_bad | (data_done & biu_err_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mem_ack_o        <= 1'b0;
      mem_err_o        <= 1'b0;
      mem_misaligned_o <= 1'b0;
    end else begin
      mem_ack_o        <= data_done & ~biu_err_i;
      mem_err_o        <= (idle_bad & fault_i) | (data_done & biu_err_i);
      mem_misaligned_o <= idle_bad & misaligned_i;
    end
  end

  // Read data for the ack cycle
  always_ff @(posedge clk_i) begin
    if (data_done) begin
      mem_q_o <= biu_q_i;
    end
  end

  // At most one response kind per cycle
  a_resp_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({mem_ack_o, mem_err_o, mem_misaligned_o}));

  // Address phase held until the BIU acks it
  a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (biu_stb_o && !biu_stb_ack_i) |=>
      (biu_stb_o && $stable(biu_adr_o) && $stable(biu_size_o) &&
       $stable(biu_we_o) && $stable(biu_d_o)));

endmodule

`default_nettype wire

//--- dmem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmem_defines.svh"

module dmem_ctrl (
  input  wire                  clk_i,
  input  wire                  rst_n_i,
  // CPU request
  input  wire                  mem_req_i,
  input  wire dmem_pkg::addr_t mem_adr_i,
  input  wire dmem_pkg::size_t mem_size_i,
  input  wire                  mem_we_i,
  input  wire dmem_pkg::data_t mem_d_i,
  output logic                 mem_ready_o,
  // CPU response
  output dmem_pkg::data_t      mem_q_o,
  output logic                 mem_ack_o,
  output logic                 mem_err_o,
  output logic                 mem_misaligned_o,
  // PMA table
  input  wire dmem_pkg::pma_cfg_t [`DMEM_PMA_CNT-1:0] pma_cfg_i,
  input  wire dmem_pkg::addr_t    [`DMEM_PMA_CNT-1:0] pma_base_i,
  input  wire dmem_pkg::addr_t    [`DMEM_PMA_CNT-1:0] pma_mask_i,
  // BIU
  output logic                 biu_stb_o,
  input  wire                  biu_stb_ack_i,
  output dmem_pkg::addr_t      biu_adr_o,
  output dmem_pkg::size_t      biu_size_o,
  output logic                 biu_we_o,
  output dmem_pkg::data_t      biu_d_o,
  input  wire dmem_pkg::data_t biu_q_i,
  input  wire                  biu_ack_i,
  input  wire                  biu_err_i
);

  ////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////

  // Buffer head
  logic            buf_valid;
  dmem_pkg::addr_t buf_adr;
  dmem_pkg::size_t buf_size;
  logic            buf_we;
  dmem_pkg::data_t buf_d;
  // Check result
  logic            chk_misaligned;
  logic            chk_fault;
  // Buffer control
  logic            buf_pop;
  logic            buf_flush;

  // In-order request queue
  dmem_membuf #(
    .DEPTH(`DMEM_BUF_DEPTH)
  ) membuf0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (mem_req_i),
    .push_adr_i  (mem_adr_i),
    .push_size_i (mem_size_i),
    .push_we_i   (mem_we_i),
    .push_d_i    (mem_d_i),
    .ready_o     (mem_ready_o),
    .pop_i       (buf_pop),
    .flush_i     (buf_flush),
    .head_valid_o(buf_valid),
    .head_adr_o  (buf_adr),
    .head_size_o (buf_size),
    .head_we_o   (buf_we),
    .head_d_o    (buf_d)
  );

  // Alignment and PMA check on the head
  dmem_pmachk pmachk0 (
    .req_i       (buf_valid),
    .adr_i       (buf_adr),
    .size_i      (buf_size),
    .we_i        (buf_we),
    .pma_cfg_i   (pma_cfg_i),
    .pma_base_i  (pma_base_i),
    .pma_mask_i  (pma_mask_i),
    .misaligned_o(chk_misaligned),
    .fault_o     (chk_fault)
  );

  // BIU transfers and CPU responses
  dmem_bus_access bus_access0 (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .head_valid_i    (buf_valid),
    .head_adr_i      (buf_adr),
    .head_size_i     (buf_size),
    .head_we_i       (buf_we),
    .head_d_i        (buf_d),
    .misaligned_i    (chk_misaligned),
    .fault_i         (chk_fault),
    .pop_o           (buf_pop),
    .flush_o         (buf_flush),
    .biu_stb_o       (biu_stb_o),
    .biu_stb_ack_i   (biu_stb_ack_i),
    .biu_adr_o       (biu_adr_o),
    .biu_size_o      (biu_size_o),
    .biu_we_o        (biu_we_o),
    .biu_d_o         (biu_d_o),
    .biu_q_i         (biu_q_i),
    .biu_ack_i       (biu_ack_i),
    .biu_err_i       (biu_err_i),
    .mem_q_o         (mem_q_o),
    .mem_ack_o       (mem_ack_o),
    .mem_err_o       (mem_err_o),
    .mem_misaligned_o(mem_misaligned_o)
  );

endmodule

`default_nettype wire

//--- tb_dmem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmem_defines.svh"

module tb_dmem_ctrl;

  // About 6 tests x 40 accesses x 8 cycles with margin
  localparam int MAX_CYCLES = 3000;

  // Response codes as {misaligned, err, ack}
  localparam logic [31:0] RESP_ACK = 32'd1;
  localparam logic [31:0] RESP_ERR = 32'd2;
  localparam logic [31:0] RESP_MIS = 32'd4;

  logic                                   clk_i;
  logic                                   rst_n_i;
  // CPU side
  logic                                   mem_req_i;
  dmem_pkg::addr_t                        mem_adr_i;
  dmem_pkg::size_t                        mem_size_i;
  logic                                   mem_we_i;
  dmem_pkg::data_t                        mem_d_i;
  logic                                   mem_ready_o;
  dmem_pkg::data_t                        mem_q_o;
  logic                                   mem_ack_o;
  logic                                   mem_err_o;
  logic                                   mem_misaligned_o;
  // PMA table
  dmem_pkg::pma_cfg_t [`DMEM_PMA_CNT-1:0] pma_cfg_i;
  dmem_pkg::addr_t    [`DMEM_PMA_CNT-1:0] pma_base_i;
  dmem_pkg::addr_t    [`DMEM_PMA_CNT-1:0] pma_mask_i;
  // BIU side
  logic                                   biu_stb_o;
  logic                                   biu_stb_ack_i;
  dmem_pkg::addr_t                        biu_adr_o;
  dmem_pkg::size_t                        biu_size_o;
  logic                                   biu_we_o;
  dmem_pkg::data_t                        biu_d_o;
  dmem_pkg::data_t                        biu_q_i;
  logic                                   biu_ack_i;
  logic                                   biu_err_i;

  // BIU model state
  dmem_pkg::data_t bmem [256];
  logic            biu_stall;
  logic            err_en;
  dmem_pkg::addr_t err_adr;
  logic            in_data;
  int              wait_cnt;
  dmem_pkg::addr_t lat_adr;
  logic            lat_we;
  dmem_pkg::data_t lat_d;

  // Observed responses in arrival order
  logic [31:0]     kind_q [$];
  dmem_pkg::data_t data_q [$];
  int              stb_cnt;
  int              cycle_cnt;
  int              errors;

  dmem_ctrl dut0 (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .mem_req_i       (mem_req_i),
    .mem_adr_i       (mem_adr_i),
    .mem_size_i      (mem_size_i),
    .mem_we_i        (mem_we_i),
    .mem_d_i         (mem_d_i),
    .mem_ready_o     (mem_ready_o),
    .mem_q_o         (mem_q_o),
    .mem_ack_o       (mem_ack_o),
    .mem_err_o       (mem_err_o),
    .mem_misaligned_o(mem_misaligned_o),
    .pma_cfg_i       (pma_cfg_i),
    .pma_base_i      (pma_base_i),
    .pma_mask_i      (pma_mask_i),
    .biu_stb_o       (biu_stb_o),
    .biu_stb_ack_i   (biu_stb_ack_i),
    .biu_adr_o       (biu_adr_o),
    .biu_size_o      (biu_size_o),
    .biu_we_o        (biu_we_o),
    .biu_d_o         (biu_d_o),
    .biu_q_i         (biu_q_i),
    .biu_ack_i       (biu_ack_i),
    .biu_err_i       (biu_err_i)
  );

  // 100 ns period
  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Start-up content that differs with the word index
  function automatic dmem_pkg::data_t fill_word(input int idx);
    return 32'h5EED_0000 ^ (idx * 32'h0101_0101);
  endfunction

  // Zero to three wait states
  function automatic int rand_wait();
    return int'($urandom % 4);
  endfunction

  function automatic logic [31:0] as_word(input logic b);
    return {31'd0, b};
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Issue one request and hold it until the buffer takes it
  task automatic send_req(input dmem_pkg::addr_t adr, input dmem_pkg::size_t size,
                          input logic we, input dmem_pkg::data_t d);
    mem_req_i  = 1'b1;
    mem_adr_i  = adr;
    mem_size_i = size;
    mem_we_i   = we;
    mem_d_i    = d;
    while (!mem_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    mem_req_i = 1'b0;
  endtask

  // Monitor counters read away from the falling edge
  task automatic snap(output int nresp, output int nstb);
    @(posedge clk_i);
    nresp = kind_q.size();
    nstb  = stb_cnt;
    @(negedge clk_i);
  endtask

  task automatic wait_resps(input int target);
    do @(posedge clk_i); while (kind_q.size() < target);
    @(negedge clk_i);
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  // BIU model controls change between falling edges
  task automatic bus_ctrl(input logic stall, input logic en, input dmem_pkg::addr_t adr);
    @(posedge clk_i);
    biu_stall = stall;
    err_en    = en;
    err_adr   = adr;
    @(negedge clk_i);
  endtask

  ////////////////////////////////////////
  // BIU memory model
  ////////////////////////////////////////

  initial begin
    biu_stb_ack_i = 1'b0;
    biu_ack_i     = 1'b0;
    biu_err_i     = 1'b0;
    biu_q_i       = '0;
    in_data       = 1'b0;
    wait_cnt      = 0;
    for (int i = 0; i < 256; i++) begin
      bmem[i] = fill_word(i);
    end
    forever begin
      @(negedge clk_i);
      biu_stb_ack_i = 1'b0;
      biu_ack_i     = 1'b0;
      biu_err_i     = 1'b0;
      if (!rst_n_i) begin
        in_data  = 1'b0;
        wait_cnt = 0;
      end else if (!in_data) begin
        // Address phase held open while stalled
        if (biu_stb_o && !biu_stall) begin
          if (wait_cnt > 0) begin
            wait_cnt--;
          end else begin
            // Every access that reaches the bus here is a word
            check("bus_size", 32'(`DMEM_SIZE_WORD), 32'(biu_size_o));
            biu_stb_ack_i = 1'b1;
            lat_adr       = biu_adr_o;
            lat_we        = biu_we_o;
            lat_d         = biu_d_o;
            in_data       = 1'b1;
            wait_cnt      = rand_wait();
          end
        end
      end else if (wait_cnt > 0) begin
        wait_cnt--;
      end else begin
        // Data phase ends with ack or forced error
        if (err_en && lat_adr == err_adr) begin
          biu_err_i = 1'b1;
        end else begin
          biu_ack_i = 1'b1;
          if (lat_we) begin
            bmem[lat_adr[9:2]] = lat_d;
          end
          biu_q_i = bmem[lat_adr[9:2]];
        end
        in_data  = 1'b0;
        wait_cnt = rand_wait();
      end
    end
  end

  // Response and strobe monitor
  initial begin
    stb_cnt = 0;
    forever begin
      @(negedge clk_i);
      if (mem_ack_o || mem_err_o || mem_misaligned_o) begin
        kind_q.push_back({29'd0, mem_misaligned_o, mem_err_o, mem_ack_o});
        data_q.push_back(mem_q_o);
      end
      if (biu_stb_o) begin
        stb_cnt++;
      end
    end
  end

  // Run limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: tests did not finish within %0d cycles, %0d errors so far",
             MAX_CYCLES, errors);
    $display(">>> FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic reset_state();
    check("reset_state ready", 32'd1, as_word(mem_ready_o));
    check("reset_state ack", 32'd0, as_word(mem_ack_o));
    check("reset_state err", 32'd0, as_word(mem_err_o));
    check("reset_state misaligned", 32'd0, as_word(mem_misaligned_o));
    check("reset_state stb", 32'd0, as_word(biu_stb_o));
  endtask

  task automatic write_then_read();
    int r0;
    int s0;
    snap(r0, s0);
    send_req(32'h0000_0040, `DMEM_SIZE_WORD, 1'b1, 32'hDEAD_BEEF);
    send_req(32'h0000_0040, `DMEM_SIZE_WORD, 1'b0, 32'h0);
    wait_resps(r0 + 2);
    check("write_then_read write kind", RESP_ACK, kind_q[r0]);
    check("write_then_read read kind", RESP_ACK, kind_q[r0+1]);
    check("write_then_read read data", 32'hDEAD_BEEF, data_q[r0+1]);
    check("write_then_read memory", 32'hDEAD_BEEF, bmem[16]);
  endtask

  task automatic back_to_back_reads();
    int r0;
    int s0;
    bus_ctrl(1'b1, 1'b0, '0);
    snap(r0, s0);
    for (int k = 0; k < 4; k++) begin
      send_req(32'h0000_0100 + 32'(4 * k), `DMEM_SIZE_WORD, 1'b0, 32'h0);
    end
    // Head still waits for the stalled BIU
    check("back_to_back_reads full", 32'd0, as_word(mem_ready_o));
    bus_ctrl(1'b0, 1'b0, '0);
    wait_resps(r0 + 4);
    for (int k = 0; k < 4; k++) begin
      check("back_to_back_reads kind", RESP_ACK, kind_q[r0+k]);
      check("back_to_back_reads data", fill_word(64 + k), data_q[r0+k]);
    end
  endtask

  task automatic misaligned_access();
    int r0;
    int s0;
    int r1;
    int s1;
    snap(r0, s0);
    send_req(32'h0000_0101, `DMEM_SIZE_HALF, 1'b0, 32'h0);
    wait_resps(r0 + 1);
    send_req(32'h0000_0102, `DMEM_SIZE_WORD, 1'b0, 32'h0);
    wait_resps(r0 + 2);
    snap(r1, s1);
    check("misaligned_access half", RESP_MIS, kind_q[r0]);
    check("misaligned_access word", RESP_MIS, kind_q[r0+1]);
    check("misaligned_access responses", 32'(r0 + 2), 32'(r1));
    check("misaligned_access strobes", 32'(s0), 32'(s1));
  endtask

  // One faulting access that must not reach the bus
  task automatic expect_fault(input string name, input dmem_pkg::addr_t adr, input logic we);
    int r0;
    int s0;
    int r1;
    int s1;
    snap(r0, s0);
    send_req(adr, `DMEM_SIZE_WORD, we, 32'h1234_5678);
    wait_resps(r0 + 1);
    snap(r1, s1);
    check(name, RESP_ERR, kind_q[r0]);
    check(name, 32'(r0 + 1), 32'(r1));
    check(name, 32'(s0), 32'(s1));
  endtask

  task automatic pma_faults();
    expect_fault("pma_faults write read-only", 32'h0000_1000, 1'b1);
    expect_fault("pma_faults read write-only", 32'h0000_2000, 1'b0);
    expect_fault("pma_faults disabled region", 32'h0000_3000, 1'b0);
    expect_fault("pma_faults unmapped", 32'h0000_8000, 1'b0);
  endtask

  task automatic fault_flush();
    int r0;
    int s0;
    int r1;
    int s1;
    int r2;
    int s2;
    bus_ctrl(1'b1, 1'b0, '0);
    snap(r0, s0);
    send_req(32'h0000_0010, `DMEM_SIZE_WORD, 1'b0, 32'h0);
    send_req(32'h0000_1004, `DMEM_SIZE_WORD, 1'b1, 32'hBAD0_0001);
    send_req(32'h0000_0014, `DMEM_SIZE_WORD, 1'b0, 32'h0);
    send_req(32'h0000_0018, `DMEM_SIZE_WORD, 1'b0, 32'h0);
    bus_ctrl(1'b0, 1'b0, '0);
    wait_resps(r0 + 2);
    snap(r1, s1);
    // Dropped reads must stay silent
    idle(20);
    snap(r2, s2);
    check("fault_flush read kind", RESP_ACK, kind_q[r0]);
    check("fault_flush read data", fill_word(4), data_q[r0]);
    check("fault_flush write kind", RESP_ERR, kind_q[r0+1]);
    check("fault_flush responses", 32'(r0 + 2), 32'(r1));
    check("fault_flush late responses", 32'(r1), 32'(r2));
    check("fault_flush strobes", 32'(s1), 32'(s2));
    check("fault_flush ready", 32'd1, as_word(mem_ready_o));
  endtask

  task automatic bus_error_recovery();
    int r0;
    int s0;
    bus_ctrl(1'b0, 1'b1, 32'h0000_0020);
    snap(r0, s0);
    send_req(32'h0000_0020, `DMEM_SIZE_WORD, 1'b0, 32'h0);
    wait_resps(r0 + 1);
    check("bus_error_recovery error kind", RESP_ERR, kind_q[r0]);
    send_req(32'h0000_0024, `DMEM_SIZE_WORD, 1'b0, 32'h0);
    wait_resps(r0 + 2);
    check("bus_error_recovery next kind", RESP_ACK, kind_q[r0+1]);
    check("bus_error_recovery next data", fill_word(9), data_q[r0+1]);
    bus_ctrl(1'b0, 1'b0, '0);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(6));
    errors     = 0;
    biu_stall  = 1'b0;
    err_en     = 1'b0;
    err_adr    = '0;
    rst_n_i    = 1'b0;
    mem_req_i  = 1'b0;
    mem_adr_i  = '0;
    mem_size_i = '0;
    mem_we_i   = 1'b0;
    mem_d_i    = '0;
    // EN is bit 0, RD bit 1, WR bit 2
    pma_cfg_i[0]  = 3'b111;
    pma_cfg_i[1]  = 3'b011;
    pma_cfg_i[2]  = 3'b101;
    pma_cfg_i[3]  = 3'b110;
    pma_base_i[0] = 32'h0000_0000;
    pma_base_i[1] = 32'h0000_1000;
    pma_base_i[2] = 32'h0000_2000;
    pma_base_i[3] = 32'h0000_3000;
    for (int i = 0; i < `DMEM_PMA_CNT; i++) begin
      pma_mask_i[i] = 32'hFFFF_F000;
    end
    repeat (10) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    reset_state();
    write_then_read();
    back_to_back_reads();
    misaligned_access();
    pma_faults();
    fault_flush();
    bus_error_recovery();
    $display("tests done, %0d errors", errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
dmem_pkg.sv
dmem_membuf.sv
dmem_pmachk.sv
dmem_bus_access.sv
dmem_ctrl.sv
tb_dmem_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the dmem_ctrl testbench with Verilator, run it and grade the log

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
sim_bin=sim_dmem_ctrl
log_file=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module tb_dmem_ctrl \
    -Mdir "$obj_dir" -o "$sim_bin"; then
  echo "verilator build failed"
  exit 1
fi

if ! "./$obj_dir/$sim_bin" > "$log_file" 2>&1; then
  cat "$log_file"
  echo "simulation exited with an error status"
  exit 1
fi

cat "$log_file"

# Verdict comes from the log only
if grep -qx '>>> PASS' "$log_file"; then
  echo "result: passed"
  exit 0
fi

echo "result: failed"
exit 1
